/* vlog.f */
+incdir+include
src/ddr_pads_pkg.sv
src/fr_wr_if.sv
src/burst_phase.sv
src/wr_serializer.sv
src/wr_pad_regs.sv
src/rd_deserializer.sv
src/ddr_pads_top.sv
sim/tb_ddr_pads.sv

/* Makefile */
# Verilator build and run of the DDR pads testbench, once per REVERSE value

VERILATOR ?= verilator
TOP       ?= tb_ddr_pads
RTL_TOP   ?= ddr_pads_top
FILELIST  ?= vlog.f
SEED      ?= 75014
REVERSE   ?= 0 1
OBJ_DIR   ?= obj_dir
LOG_DIR   ?= logs
VFLAGS    ?= --binary --timing -j 0

.PHONY: all lint clean

all: $(addprefix run_rev,$(REVERSE))

run_rev%:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) -GREVERSE_READ_WORDS=$* --Mdir $(OBJ_DIR)_rev$* -o sim_$(TOP)
	@mkdir -p $(LOG_DIR)
	-./$(OBJ_DIR)_rev$*/sim_$(TOP) > $(LOG_DIR)/sim_rev$*.log 2>&1
	@cat $(LOG_DIR)/sim_rev$*.log
	@if grep -q "TEST FAIL" $(LOG_DIR)/sim_rev$*.log; then \
		echo "Simulation failed with REVERSE=$*"; exit 1; \
	fi
	@grep -q "TEST PASS" $(LOG_DIR)/sim_rev$*.log || \
		{ echo "No pass line in log with REVERSE=$*"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)_rev* $(LOG_DIR)

/* sim/tb_ddr_pads.sv */
// Single-clock random run of one DQ group; the first wrong output stops the run
`default_nettype none

module tb_ddr_pads #(
    parameter bit REVERSE_READ_WORDS = 1'b0,
    parameter int SEED               = 75014
);
    timeunit 1ns;
    timeprecision 100ps;

    import ddr_pads_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 2;
    localparam int NUM_WORDS       = 600;
    localparam int WATCHDOG_CYCLES = NUM_WORDS * 2 + 50;
    localparam int PW              = $bits(pin_vec_t);

    logic       pll_mem_clk;
    logic       rst_n;
    logic       mem_clk_en;
    hr_word_t   write_data;
    hr_oe_t     write_oe;
    logic [1:0] strobe_ena;
    fr_pair_t   rd_fr_data;
    pin_vec_t   dq_lo;
    pin_vec_t   dq_hi;
    pin_vec_t   dq_oe;
    logic       dqs_oe;
    hr_word_t   rdata_hr;
    logic       rdata_valid;

    integer     seed;
    int         dq_gap_left;
    int         dq_burst_left;
    int         dqs_gap_left;
    int         dqs_burst_left;
    int         oe_seen;
    int         dqs_seen;
    int         valid_seen;
    int         gated_seen;

    // ##############################
    // Reference model state
    // ##############################

    hr_word_t   prev_word;       // Inputs sampled at the previous edge
    hr_oe_t     prev_oe;
    logic [1:0] prev_strobe;
    logic       dq_active_q;
    logic       dqs_active_q;
    beat_half_t dq_half_m;
    beat_half_t dqs_half_m;
    pin_vec_t   ser_lo_q;        // Serializer output, one edge old
    pin_vec_t   ser_hi_q;
    pin_vec_t   ser_oe_q;
    logic       ser_dqs_q;
    logic       dqs_pad_q;       // Extra strobe enable delay
    fr_pair_t   rd_pair_d1;      // Ordered read pair from one edge back
    fr_pair_t   rd_pair_d2;
    int         rd_edges;

    pin_vec_t   exp_dq_lo;
    pin_vec_t   exp_dq_hi;
    pin_vec_t   exp_dq_oe;
    logic       exp_dqs_oe;
    logic       exp_clk_en;
    hr_word_t   exp_rdata_hr;
    logic       exp_rdata_valid;

    ddr_pads_top #(
        .REVERSE_READ_WORDS (REVERSE_READ_WORDS)
    ) DUT (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .mem_clk_en  (mem_clk_en),
        .write_data  (write_data),
        .write_oe    (write_oe),
        .strobe_ena  (strobe_ena),
        .dq_lo       (dq_lo),
        .dq_hi       (dq_hi),
        .dq_oe       (dq_oe),
        .dqs_oe      (dqs_oe),
        .rd_fr_data  (rd_fr_data),
        .rdata_hr    (rdata_hr),
        .rdata_valid (rdata_valid)
    );

    initial
    begin
        pll_mem_clk = 1'b0;
        forever #(CLK_PERIOD / 2) pll_mem_clk = ~pll_mem_clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d clock periods", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "Simulation did not finish in time");
    end

    // ##############################
    // Random helpers
    // ##############################

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    function automatic pin_vec_t random_pins();
        logic [31:0] r;
        r = $random(seed);
        return r[PW-1:0];
    endfunction

    function automatic pin_vec_t beat_of(input hr_word_t w, input int t);
        return w[t*PW +: PW];
    endfunction

    // Read pair as it lands in the capture stage
    function automatic fr_pair_t order_pair(input fr_pair_t p);
        if (REVERSE_READ_WORDS)
            return {p[PW-1:0], p[2*PW-1:PW]};
        return p;
    endfunction

    // ##############################
    // Compare tasks
    // ##############################

    task automatic check_pair(input string name, input pin_vec_t expected, input pin_vec_t actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s at %0t: expected %h, actual %h", name, $time, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Output check failed");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s at %0t: expected %h, actual %h", name, $time, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Output check failed");
        end
    endtask

    task automatic check_word(input string name, input hr_word_t expected, input hr_word_t actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s at %0t: expected %h, actual %h", name, $time, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Output check failed");
        end
    endtask

    // Advance the model by one edge, using the inputs the DUT samples at this edge
    task automatic model_edge();
        logic     dq_start;
        logic     dqs_start;
        pin_vec_t new_lo;
        pin_vec_t new_hi;
        pin_vec_t new_oe;
        logic     new_dqs;
        if (!rst_n)
        begin
            {prev_word, prev_oe, prev_strobe} = '0;
            {dq_active_q, dqs_active_q} = 2'b00;
            dq_half_m  = HALF_LATE;
            dqs_half_m = HALF_LATE;
            {ser_lo_q, ser_hi_q, ser_oe_q, ser_dqs_q, dqs_pad_q} = '0;
            {rd_pair_d1, rd_pair_d2} = '0;
            rd_edges = 0;
            {exp_dq_lo, exp_dq_hi, exp_dq_oe, exp_dqs_oe, exp_clk_en} = '0;
            exp_rdata_hr    = '0;
            exp_rdata_valid = 1'b0;
        end
        else
        begin
            dq_start  = (|write_oe) && !dq_active_q;
            dqs_start = (|strobe_ena) && !dqs_active_q;
            if (dq_start || dq_half_m == HALF_LATE)    // Load edge sends t0/t1
            begin
                new_lo = beat_of(write_data, 0);
                new_hi = beat_of(write_data, 1);
                new_oe = write_oe[PW-1:0];
            end
            else    // Late pair of the word loaded one edge before
            begin
                new_lo = beat_of(prev_word, 2);
                new_hi = beat_of(prev_word, 3);
                new_oe = prev_oe[2*PW-1:PW];
            end
            if (dqs_start || dqs_half_m == HALF_LATE)
                new_dqs = strobe_ena[0];
            else
                new_dqs = prev_strobe[1];
            dq_half_m  = dq_start ? HALF_EARLY : beat_half_t'(~dq_half_m);
            dqs_half_m = dqs_start ? HALF_EARLY : beat_half_t'(~dqs_half_m);
            dq_active_q  = |write_oe;
            dqs_active_q = |strobe_ena;

            // Pad stage, enables gated by the clock enable seen at this edge
            exp_clk_en = mem_clk_en;
            exp_dq_lo  = ser_lo_q;
            exp_dq_hi  = ser_hi_q;
            exp_dq_oe  = exp_clk_en ? ser_oe_q : '0;
            exp_dqs_oe = dqs_pad_q & exp_clk_en;
            dqs_pad_q  = ser_dqs_q;
            {ser_lo_q, ser_hi_q, ser_oe_q, ser_dqs_q} = {new_lo, new_hi, new_oe, new_dqs};
            {prev_word, prev_oe, prev_strobe} = {write_data, write_oe, strobe_ena};

            rd_edges++;
            exp_rdata_valid = (rd_edges % 2 == 0);    // Phase is 1 on even edges
            if (exp_rdata_valid)
                exp_rdata_hr = {rd_pair_d1, rd_pair_d2};
            rd_pair_d2 = rd_pair_d1;
            rd_pair_d1 = order_pair(rd_fr_data);
        end
    endtask

    // Bursts of whole words with idle gaps, each side on its own schedule
    task automatic drive_stimulus();
        hr_oe_t     oe;
        logic [1:0] se;
        if (dq_gap_left == 0 && dq_burst_left == 0)
        begin
            dq_gap_left   = 1 + rand_below(6);
            dq_burst_left = 2 * (1 + rand_below(8));
        end
        if (dqs_gap_left == 0 && dqs_burst_left == 0)
        begin
            dqs_gap_left   = 1 + rand_below(7);
            dqs_burst_left = 2 * (1 + rand_below(6));
        end
        if (dq_gap_left > 0)
        begin
            oe = '0;
            dq_gap_left--;
        end
        else
        begin
            oe = {random_pins(), random_pins()};
            if (oe == '0)
                oe[0] = 1'b1;    // Keep the burst active
            dq_burst_left--;
        end
        if (dqs_gap_left > 0)
        begin
            se = 2'b00;
            dqs_gap_left--;
        end
        else
        begin
            se = 2'(1 + rand_below(3));
            dqs_burst_left--;
        end
        write_data <= {random_pins(), random_pins(), random_pins(), random_pins()};
        write_oe   <= oe;
        strobe_ena <= se;
        mem_clk_en <= (rand_below(8) != 0);    // Mostly running
        rd_fr_data <= {random_pins(), random_pins()};
    endtask

    task automatic check_outputs();
        check_pair("dq_lo", exp_dq_lo, dq_lo);
        check_pair("dq_hi", exp_dq_hi, dq_hi);
        check_pair("dq_oe", exp_dq_oe, dq_oe);
        check_bit("dqs_oe", exp_dqs_oe, dqs_oe);
        check_bit("rdata_valid", exp_rdata_valid, rdata_valid);
        check_word("rdata_hr", exp_rdata_hr, rdata_hr);
        if (dq_oe != '0)
            oe_seen++;
        if (dqs_oe)
            dqs_seen++;
        if (rdata_valid)
            valid_seen++;
        if (rd_edges > 0 && !exp_clk_en)    // Clock enable sampled low out of reset
            gated_seen++;
    endtask

    // ##############################
    // Main sequence
    // ##############################

    initial
    begin
        seed       = SEED;
        rst_n      = 1'b0;
        mem_clk_en = 1'b0;
        write_data = '0;
        write_oe   = '0;
        strobe_ena = 2'b00;
        rd_fr_data = '0;
        {dq_gap_left, dq_burst_left, dqs_gap_left, dqs_burst_left} = '0;
        {oe_seen, dqs_seen, valid_seen, gated_seen} = '0;

        // Reset cycles and the idle gap after them cover the all-zero state
        for (int cyc = 0; cyc < RESET_CYCLES + NUM_WORDS * 2; cyc++)
        begin
            @(posedge pll_mem_clk);
            model_edge();
            if (cyc == RESET_CYCLES - 1)
                rst_n <= 1'b1;
            if (cyc >= RESET_CYCLES - 1)
                drive_stimulus();
            @(negedge pll_mem_clk);
            check_outputs();
        end

        if (oe_seen == 0 || dqs_seen == 0 || valid_seen == 0 || gated_seen == 0)
        begin
            $display("Stimulus never reached a write enable, strobe enable, read word or gate");
            $display("TEST FAIL");
            $fatal(1, "Stimulus check failed");
        end
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* src/ddr_pads_top.sv */
// Single clock model of one DQ/DQS group; pads, DQS toggle and separate PHY clocks are not modelled
`default_nettype none

module ddr_pads_top #(
    parameter bit REVERSE_READ_WORDS = 1'b0
) (
    input  wire logic                    pll_mem_clk,
    input  wire logic                    rst_n,
    input  wire logic                    mem_clk_en,

    // Half-rate write side
    input  wire ddr_pads_pkg::hr_word_t  write_data,
    input  wire ddr_pads_pkg::hr_oe_t    write_oe,
    input  wire logic [1:0]              strobe_ena,    // Bit 0 early, bit 1 late

    // Full-rate pad side
    output wire ddr_pads_pkg::pin_vec_t  dq_lo,
    output wire ddr_pads_pkg::pin_vec_t  dq_hi,
    output wire ddr_pads_pkg::pin_vec_t  dq_oe,
    output wire logic                    dqs_oe,
    input  wire ddr_pads_pkg::fr_pair_t  rd_fr_data,

    // Half-rate read side
    output wire ddr_pads_pkg::hr_word_t  rdata_hr,
    output wire logic                    rdata_valid
);

    // ##############################
    // Write path
    // ##############################

    fr_wr_if fr_bus ();    // Serializer to pad registers

    wr_serializer wr_ser (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .write_data  (write_data),
        .write_oe    (write_oe),
        .strobe_ena  (strobe_ena),
        .fr          (fr_bus.src)
    );

    wr_pad_regs pad_regs (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .mem_clk_en  (mem_clk_en),
        .fr          (fr_bus.dst),
        .dq_lo       (dq_lo),
        .dq_hi       (dq_hi),
        .dq_oe       (dq_oe),
        .dqs_oe      (dqs_oe)
    );

    // ##############################
    // Read path
    // ##############################

    rd_deserializer #(
        .REVERSE_READ_WORDS (REVERSE_READ_WORDS)
    ) rd_deser (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .rd_fr_data  (rd_fr_data),
        .rdata_hr    (rdata_hr),
        .rdata_valid (rdata_valid)
    );

endmodule

`default_nettype wire

/* src/rd_deserializer.sv */
// Read pairs are taken every edge; the half-rate phase free-runs from reset with no word alignment
`default_nettype none

module rd_deserializer #(
    parameter bit REVERSE_READ_WORDS = 1'b0
) (
    input  wire logic                   pll_mem_clk,
    input  wire logic                   rst_n,
    input  wire ddr_pads_pkg::fr_pair_t rd_fr_data,
    output ddr_pads_pkg::hr_word_t      rdata_hr,
    output logic                        rdata_valid
);
    import ddr_pads_pkg::*;

    pin_vec_t rd_lo;
    pin_vec_t rd_hi;
    fr_pair_t rd_ordered;
    fr_pair_t rd_r;       // Pair from the previous edge
    fr_pair_t rd_r1;      // Pair from two edges back
    logic     phase;

    assign {rd_hi, rd_lo} = rd_fr_data;

    // Optional swap of the beat order within a pair
    assign rd_ordered = REVERSE_READ_WORDS ? {rd_lo, rd_hi} : {rd_hi, rd_lo};

    // ##############################
    // Capture pipeline and FR to HR
    // ##############################

    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_r        <= '0;
            rd_r1       <= '0;
            phase       <= 1'b0;
            rdata_hr    <= '0;
            rdata_valid <= 1'b0;
        end
        else
        begin
            rd_r  <= rd_ordered;
            rd_r1 <= rd_r;
            phase <= ~phase;    // Stands in for the divided capture clock

            if (phase)
                rdata_hr <= {rd_r, rd_r1};    // Newer pair on top
            rdata_valid <= phase;             // One cycle per loaded word
        end
    end

endmodule

`default_nettype wire

/* src/wr_pad_regs.sv */
// Clock enable is sampled here so enables drop one edge after mem_clk_en is seen low
`default_nettype none

module wr_pad_regs (
    input  wire logic               pll_mem_clk,
    input  wire logic               rst_n,
    input  wire logic               mem_clk_en,
    fr_wr_if.dst                    fr,
    output ddr_pads_pkg::pin_vec_t  dq_lo,
    output ddr_pads_pkg::pin_vec_t  dq_hi,
    output ddr_pads_pkg::pin_vec_t  dq_oe,
    output logic                    dqs_oe
);
    import ddr_pads_pkg::*;

    pin_vec_t dq_oe_q;
    logic     dqs_oe_q1;
    logic     dqs_oe_q2;    // Extra strobe enable stage
    logic     clk_en_q;

    // ##############################
    // Output registers
    // ##############################

    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dq_lo     <= '0;
            dq_hi     <= '0;
            dq_oe_q   <= '0;
            dqs_oe_q1 <= 1'b0;
            dqs_oe_q2 <= 1'b0;
            clk_en_q  <= 1'b0;
        end
        else
        begin
            dq_lo     <= fr.dq_lo;
            dq_hi     <= fr.dq_hi;
            dq_oe_q   <= fr.dq_oe;
            dqs_oe_q1 <= fr.dqs_oe;
            dqs_oe_q2 <= dqs_oe_q1;
            clk_en_q  <= mem_clk_en;
        end
    end

    // Enables off while the memory clock is stopped
    assign dq_oe  = dq_oe_q & {$bits(pin_vec_t){clk_en_q}};
    assign dqs_oe = dqs_oe_q2 & clk_en_q;

endmodule

`default_nettype wire

/* src/wr_serializer.sv */
// Host must present word n at burst start edge + 2n; input words between load edges are ignored
`default_nettype none

module wr_serializer (
    input  wire logic                   pll_mem_clk,
    input  wire logic                   rst_n,
    input  wire ddr_pads_pkg::hr_word_t write_data,
    input  wire ddr_pads_pkg::hr_oe_t   write_oe,
    input  wire logic [1:0]             strobe_ena,
    fr_wr_if.src                        fr
);
    import ddr_pads_pkg::*;

    pin_vec_t   beat_t0;
    pin_vec_t   beat_t1;
    pin_vec_t   beat_t2;
    pin_vec_t   beat_t3;
    pin_vec_t   oe_early;
    pin_vec_t   oe_late;

    logic       dq_start;
    logic       dqs_start;
    beat_half_t dq_half;
    beat_half_t dqs_half;
    logic       dq_load;
    logic       dqs_load;

    fr_pair_t   late_pair_hold;    // t3 over t2
    pin_vec_t   late_oe_hold;
    logic       late_dqs_hold;

    assign {beat_t3, beat_t2, beat_t1, beat_t0} = write_data;
    assign {oe_late, oe_early} = write_oe;

    // ##############################
    // Burst alignment
    // ##############################

    burst_phase dq_phase (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .active      (|write_oe),
        .start       (dq_start),
        .half        (dq_half)
    );

    burst_phase dqs_phase (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .active      (|strobe_ena),
        .start       (dqs_start),
        .half        (dqs_half)
    );

    assign dq_load  = dq_start  | (dq_half  == HALF_LATE);
    assign dqs_load = dqs_start | (dqs_half == HALF_LATE);

    // ##############################
    // Late half holding registers
    // ##############################

    always_ff @(posedge pll_mem_clk)
    begin
        if (dq_load)
        begin
            late_pair_hold <= {beat_t3, beat_t2};
            late_oe_hold   <= oe_late;
        end
    end

    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fr.dq_lo      <= '0;
            fr.dq_hi      <= '0;
            fr.dq_oe      <= '0;
            fr.dqs_oe     <= 1'b0;
            late_dqs_hold <= 1'b0;
        end
        else
        begin
            if (dq_load)
            begin
                fr.dq_lo <= beat_t0;     // Early pair straight from the input
                fr.dq_hi <= beat_t1;
                fr.dq_oe <= oe_early;
            end
            else
            begin
                {fr.dq_hi, fr.dq_lo} <= late_pair_hold;
                fr.dq_oe             <= late_oe_hold;
            end

            if (dqs_load)
            begin
                fr.dqs_oe     <= strobe_ena[0];
                late_dqs_hold <= strobe_ena[1];
            end
            else
                fr.dqs_oe <= late_dqs_hold;
        end
    end

endmodule

`default_nettype wire

/* src/burst_phase.sv */
// Start is combinational on active; half free-runs between bursts and only realigns at a start
`default_nettype none

module burst_phase (
    input  wire logic               pll_mem_clk,
    input  wire logic               rst_n,
    input  wire logic               active,
    output logic                    start,
    output ddr_pads_pkg::beat_half_t half
);
    import ddr_pads_pkg::*;

    logic active_q;    // Level seen at the previous edge

    // Rising edge of the burst
    assign start = active & ~active_q;

    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active_q <= 1'b0;
            half     <= HALF_LATE;    // First edge after reset is a load edge
        end
        else
        begin
            active_q <= active;
            if (start)
                half <= HALF_EARLY;    // Realign on a new burst
            else
                half <= (half == HALF_EARLY) ? HALF_LATE : HALF_EARLY;
        end
    end

endmodule

`default_nettype wire

/* src/fr_wr_if.sv */
// Registered every cycle by the source side; no handshake, the sink samples unconditionally
`default_nettype none

interface fr_wr_if;
    import ddr_pads_pkg::*;

    pin_vec_t dq_lo;     // Low beat of the pair
    pin_vec_t dq_hi;     // High beat of the pair
    pin_vec_t dq_oe;     // Per-pin write enable
    logic     dqs_oe;    // Strobe enable before the extra delay

    // Serializer side
    modport src
    (
        output dq_lo,
        output dq_hi,
        output dq_oe,
        output dqs_oe
    );

    // Pad register side
    modport dst
    (
        input dq_lo,
        input dq_hi,
        input dq_oe,
        input dqs_oe
    );

endinterface

`default_nettype wire

/* src/ddr_pads_pkg.sv */
// Vector widths follow ddr_pads_defs.svh; the beat ordering t0..t3 from LSB up is assumed everywhere
`default_nettype none

`include "ddr_pads_defs.svh"

package ddr_pads_pkg;

    // ##############################
    // Datapath vectors
    // ##############################

    typedef logic [`DDR_PIN_WIDTH-1:0] pin_vec_t;                    // One bit per DQ pin

    typedef logic [2*`DDR_PIN_WIDTH-1:0] fr_pair_t;                  // Low beat in lower half

    typedef logic [`DDR_HR_BEATS*`DDR_PIN_WIDTH-1:0] hr_word_t;      // Beat t0 in lowest slice

    // Early half enables in the low slice, late half in the high slice
    typedef logic [2*`DDR_PIN_WIDTH-1:0] hr_oe_t;

    // ##############################
    // Beat-half selector
    // ##############################

    typedef enum logic
    {
        HALF_EARLY = 1'b0,    // Sending t0/t1
        HALF_LATE  = 1'b1     // Sending t2/t3
    } beat_half_t;

endpackage

`default_nettype wire

/* include/ddr_pads_defs.svh */
// One DQ group per build; beats per half-rate word must stay at 4 for the serializer slicing
`ifndef DDR_PADS_DEFS_SVH
`define DDR_PADS_DEFS_SVH

// ##############################
// Group geometry
// ##############################

// DQ pins in one group
`define DDR_PIN_WIDTH 8

// Full-rate beats carried by one half-rate word
`define DDR_HR_BEATS 4

`endif
